//--- project.f
+incdir+.
jp_pkg.sv
pad_link_if.sv
pad_bit_timer.sv
pad_poll_fsm.sv
pad_shift_reg.sv
p1_register.sv
joypad_top.sv
jp_sva.sv
tb_joypad.sv

//--- run_sim.sh
#!/bin/sh
# build and run the joypad testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_joypad -f project.f -o tb_joypad
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

output=$(./obj_dir/tb_joypad)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "ALL CHECKS PASSED"; then
   exit 0
fi
exit 1

//--- tb_joypad.sv
`include "jp_cfg.svh"

module tb_joypad;

   localparam int CLK_PERIOD = 100;
   localparam logic [15:0] P1_ADDR = `JP_P1_ADDR;
   // a little more than one full poll cycle in system clocks
   localparam int FRAME_CLKS = (`JP_POLL_GAP + 2 * `JP_FRAME_BITS + 2) * `JP_TICK_DIV;
   localparam int EDGE_LIMIT = 2 * FRAME_CLKS;
   localparam int IRQ_WINDOW = 3 * FRAME_CLKS;

   logic             I_CLK = 1'b0;
   logic             I_RESET;
   logic [15:0]      ioreg_addr;
   logic [7:0]       ioreg_wdata;
   logic             ioreg_we;
   logic             ioreg_re;
   logic             pad_data = 1'b1;   // idle line reads as released
   logic [7:0]       ioreg_rdata;
   logic             pad_latch;
   logic             pad_pulse;
   logic             joypad_irq;

   jp_pkg::buttons_t pad_state = '0;   // buttons held on the modelled pad
   logic [7:0]       next_wire;
   logic [7:0]       wire_q = 8'hFF;
   logic             latch_q = 1'b0;
   logic             pulse_q = 1'b0;
   int               check_count = 0;
   int               error_count = 0;

   joypad_top i_dut (
      .I_CLK       (I_CLK),
      .I_RESET     (I_RESET),
      .ioreg_addr  (ioreg_addr),
      .ioreg_wdata (ioreg_wdata),
      .ioreg_we    (ioreg_we),
      .ioreg_re    (ioreg_re),
      .pad_data    (pad_data),
      .ioreg_rdata (ioreg_rdata),
      .pad_latch   (pad_latch),
      .pad_pulse   (pad_pulse),
      .joypad_irq  (joypad_irq)
   );

   always #(CLK_PERIOD / 2) I_CLK = ~I_CLK;

   // serial order on the wire is A first and RIGHT last, low means pressed
   function automatic logic [7:0] wire_bits(input jp_pkg::buttons_t b);
      return ~{b[jp_pkg::RIGHT], b[jp_pkg::LEFT], b[jp_pkg::DOWN], b[jp_pkg::UP],
               b[jp_pkg::START], b[jp_pkg::SELECT], b[jp_pkg::B], b[jp_pkg::A]};
   endfunction

   function automatic logic [7:0] expected_row(input jp_pkg::buttons_t b,
                                               input logic [1:0] sel);
      if (sel[1]) begin
         return {4'h0, b[jp_pkg::START], b[jp_pkg::SELECT], b[jp_pkg::A], b[jp_pkg::B]};
      end
      if (sel[0]) begin
         return {4'h0, b[jp_pkg::DOWN], b[jp_pkg::UP], b[jp_pkg::LEFT], b[jp_pkg::RIGHT]};
      end
      return 8'h00;
   endfunction

   assign next_wire = wire_bits(pad_state);

   // pad model reacts to latch and pulse edges seen on the falling clock
   always @(negedge I_CLK) begin
      if (pad_latch && !latch_q) begin
         wire_q   <= next_wire;
         pad_data <= next_wire[0];
      end else if (!pad_pulse && pulse_q) begin
         wire_q   <= {1'b1, wire_q[7:1]};   // ones follow once the frame is out
         pad_data <= wire_q[1];
      end
      latch_q <= pad_latch;
      pulse_q <= pad_pulse;
   end

   task automatic check_value(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
      check_count++;
      assert (got === exp) else begin
         $display("error %s got 0x%h expected 0x%h", name, got, exp);
         error_count++;
      end
   endtask

   task automatic p1_write(input logic [15:0] addr, input logic [7:0] data);
      @(negedge I_CLK);
      ioreg_addr  = addr;
      ioreg_wdata = data;
      ioreg_we    = 1'b1;
      @(negedge I_CLK);
      ioreg_we    = 1'b0;
   endtask

   task automatic p1_read(input logic [15:0] addr, output logic [7:0] data);
      @(negedge I_CLK);
      ioreg_addr = addr;
      ioreg_re   = 1'b1;
      #(CLK_PERIOD / 4);   // well inside the low phase
      data = ioreg_rdata;
      @(negedge I_CLK);
      ioreg_re   = 1'b0;
   endtask

   task automatic wait_latch_rise();
      int  cycles;
      bit  seen_low;
      bit  risen;
      cycles   = 0;
      seen_low = 1'b0;
      risen    = 1'b0;
      while (!risen && cycles < EDGE_LIMIT) begin
         @(negedge I_CLK);
         cycles++;
         if (!pad_latch) begin
            seen_low = 1'b1;
         end else if (seen_low) begin
            risen = 1'b1;
         end
      end
      check_count++;
      assert (risen) else begin
         $display("pad_latch did not rise within %0d clocks", EDGE_LIMIT);
         error_count++;
      end
   endtask

   // the second latch starts only after a frame holding pad_state is out
   task automatic settle_frames();
      wait_latch_rise();
      wait_latch_rise();
   endtask

   task automatic count_irq(output int pulses);
      pulses = 0;
      for (int i = 0; i < IRQ_WINDOW; i++) begin
         @(negedge I_CLK);
         if (joypad_irq) pulses++;
      end
   endtask

   task automatic test_reset_state();
      int         start_errors;
      int         pulses;
      logic [7:0] data;
      start_errors = error_count;
      for (int sel = 0; sel < 4; sel++) begin
         p1_write(P1_ADDR, {2'b00, 2'(sel), 4'h0});
         p1_read(P1_ADDR, data);
         check_value("ioreg_rdata", data, 8'h00);
      end
      count_irq(pulses);
      check_value("joypad_irq pulses", 8'(pulses), 8'h00);
      $display("test reset_state finished with %0d errors", error_count - start_errors);
   endtask

   task automatic test_direction_row();
      int         start_errors;
      logic [7:0] data;
      start_errors = error_count;
      p1_write(P1_ADDR, 8'h10);
      pad_state = '0;
      pad_state[3:0] = 4'($urandom);   // RIGHT, LEFT, UP and DOWN only
      settle_frames();
      p1_read(P1_ADDR, data);
      check_value("ioreg_rdata", data,
                  {4'h0, pad_state[jp_pkg::DOWN], pad_state[jp_pkg::UP],
                   pad_state[jp_pkg::LEFT], pad_state[jp_pkg::RIGHT]});
      $display("test direction_row finished with %0d errors", error_count - start_errors);
   endtask

   task automatic test_action_row();
      int         start_errors;
      logic [7:0] data;
      logic [7:0] act;
      start_errors = error_count;
      pad_state = 8'($urandom);
      settle_frames();
      act = {4'h0, pad_state[jp_pkg::START], pad_state[jp_pkg::SELECT],
             pad_state[jp_pkg::A], pad_state[jp_pkg::B]};
      p1_write(P1_ADDR, 8'h20);
      p1_read(P1_ADDR, data);
      check_value("ioreg_rdata", data, act);
      p1_write(P1_ADDR, 8'h30);   // both rows selected, action wins
      p1_read(P1_ADDR, data);
      check_value("ioreg_rdata", data, act);
      p1_write(P1_ADDR, 8'h00);
      p1_read(P1_ADDR, data);
      check_value("ioreg_rdata", data, 8'h00);
      $display("test action_row finished with %0d errors", error_count - start_errors);
   endtask

   task automatic test_interrupt();
      int start_errors;
      int pulses;
      start_errors = error_count;
      pad_state = '0;
      settle_frames();
      pad_state = 8'($urandom);
      if (pad_state == 8'h00) pad_state = 8'h80;
      count_irq(pulses);
      check_value("joypad_irq pulses on press", 8'(pulses), 8'h01);
      count_irq(pulses);
      check_value("joypad_irq pulses on hold", 8'(pulses), 8'h00);
      pad_state = '0;
      count_irq(pulses);
      check_value("joypad_irq pulses on release", 8'(pulses), 8'h00);
      $display("test interrupt finished with %0d errors", error_count - start_errors);
   endtask

   task automatic test_address_decode();
      int         start_errors;
      logic [7:0] data;
      start_errors = error_count;
      pad_state = 8'h0F;   // rows differ so a select change would show
      settle_frames();
      p1_write(P1_ADDR, 8'h10);
      p1_write(P1_ADDR + 16'd1, 8'h20);
      p1_read(P1_ADDR + 16'd1, data);
      check_value("ioreg_rdata off address", data, 8'h00);
      p1_read(P1_ADDR, data);
      check_value("ioreg_rdata", data, expected_row(pad_state, 2'b01));
      $display("test address_decode finished with %0d errors", error_count - start_errors);
   endtask

   task automatic test_random_frames();
      int         start_errors;
      logic [1:0] sel;
      logic [7:0] data;
      start_errors = error_count;
      for (int i = 0; i < 20; i++) begin
         pad_state = 8'($urandom);
         sel       = 2'($urandom);
         p1_write(P1_ADDR, {2'b00, sel, 4'h0});
         settle_frames();
         p1_read(P1_ADDR, data);
         check_value("ioreg_rdata", data, expected_row(pad_state, sel));
      end
      $display("test random_frames finished with %0d errors", error_count - start_errors);
   endtask

   initial begin
      void'($urandom(32'hc002b5fc));
      I_RESET     = 1'b1;
      ioreg_addr  = 16'h0000;
      ioreg_wdata = 8'h00;
      ioreg_we    = 1'b0;
      ioreg_re    = 1'b0;
      repeat (4) @(negedge I_CLK);
      I_RESET = 1'b0;

      test_reset_state();
      test_direction_row();
      test_action_row();
      test_interrupt();
      test_address_decode();
      test_random_frames();

      $display("%0d checks, %0d errors", check_count, error_count);
      if (error_count == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

//--- jp_sva.sv
module jp_sva #(
   parameter bit WATCH_POLL = 1'b1   // set on the FSM side, clear on the register side
) (
   input logic       I_CLK,
   input logic       I_RESET,
   input logic       pad_latch,
   input logic       pad_pulse,
   input logic       joypad_irq,
   input logic [7:0] ioreg_rdata
);

   if (WATCH_POLL) begin : g_poll
      // latch and clock lines of the pad must never overlap
      latch_pulse_apart: assert property (@(posedge I_CLK) disable iff (I_RESET)
         !(pad_latch && pad_pulse))
         else $error("pad_latch and pad_pulse were high together");
   end else begin : g_p1
      irq_one_cycle: assert property (@(posedge I_CLK) disable iff (I_RESET)
         joypad_irq |=> !joypad_irq)
         else $error("joypad_irq stayed high for two cycles");

      rdata_upper_zero: assert property (@(posedge I_CLK)
         ioreg_rdata[7:4] == 4'h0)
         else $error("upper nibble of ioreg_rdata was not zero");
   end

endmodule

// each instance only watches the signals its host module owns
bind pad_poll_fsm jp_sva #(.WATCH_POLL(1'b1)) i_sva_fsm (
   .I_CLK       (I_CLK),
   .I_RESET     (I_RESET),
   .pad_latch   (pad_latch),
   .pad_pulse   (pad_pulse),
   .joypad_irq  (1'b0),
   .ioreg_rdata (8'h00)
);

bind p1_register jp_sva #(.WATCH_POLL(1'b0)) i_sva_p1 (
   .I_CLK       (I_CLK),
   .I_RESET     (I_RESET),
   .pad_latch   (1'b0),
   .pad_pulse   (1'b0),
   .joypad_irq  (joypad_irq),
   .ioreg_rdata (ioreg_rdata)
);

//--- joypad_top.sv
module joypad_top (
   input  logic        I_CLK,
   input  logic        I_RESET,
   input  logic [15:0] ioreg_addr,
   input  logic [7:0]  ioreg_wdata,
   input  logic        ioreg_we,
   input  logic        ioreg_re,
   input  logic        pad_data,
   output logic [7:0]  ioreg_rdata,
   output logic        pad_latch,
   output logic        pad_pulse,
   output logic        joypad_irq
);

   jp_pkg::buttons_t buttons;   // last complete frame from the pad

   pad_link_if link ();

   pad_bit_timer i_timer (
      .I_CLK   (I_CLK),
      .I_RESET (I_RESET),
      .link    (link.timer)
   );

   pad_poll_fsm i_fsm (
      .I_CLK     (I_CLK),
      .I_RESET   (I_RESET),
      .link      (link.fsm),
      .pad_latch (pad_latch),
      .pad_pulse (pad_pulse)
   );

   pad_shift_reg i_shift (
      .I_CLK    (I_CLK),
      .I_RESET  (I_RESET),
      .link     (link.shifter),
      .pad_data (pad_data),
      .buttons  (buttons)
   );

   // CPU side register and interrupt
   p1_register i_p1 (
      .I_CLK       (I_CLK),
      .I_RESET     (I_RESET),
      .ioreg_addr  (ioreg_addr),
      .ioreg_wdata (ioreg_wdata),
      .ioreg_we    (ioreg_we),
      .ioreg_re    (ioreg_re),
      .buttons     (buttons),
      .ioreg_rdata (ioreg_rdata),
      .joypad_irq  (joypad_irq)
   );

endmodule

//--- p1_register.sv
`include "jp_cfg.svh"

module p1_register (
   input  logic             I_CLK,
   input  logic             I_RESET,
   input  logic [15:0]      ioreg_addr,
   input  logic [7:0]       ioreg_wdata,
   input  logic             ioreg_we,
   input  logic             ioreg_re,
   input  jp_pkg::buttons_t buttons,
   output logic [7:0]       ioreg_rdata,
   output logic             joypad_irq
);

   logic       p1_hit;
   logic [1:0] p1_sel;        // bit 1 picks the action row, bit 0 the direction row
   logic [3:0] dir_row;
   logic [3:0] act_row;
   logic [3:0] row_data;
   logic       any_pressed;
   logic       any_pressed_d;

   assign p1_hit = (ioreg_addr == `JP_P1_ADDR);

   always_ff @(posedge I_CLK) begin
      if (I_RESET) begin
         p1_sel <= 2'b00;
      end else if (ioreg_we && p1_hit) begin
         p1_sel <= ioreg_wdata[5:4];
      end
   end

   // rows in the bit order software expects
   assign dir_row = {buttons[jp_pkg::DOWN], buttons[jp_pkg::UP],
                     buttons[jp_pkg::LEFT], buttons[jp_pkg::RIGHT]};
   assign act_row = {buttons[jp_pkg::START], buttons[jp_pkg::SELECT],
                     buttons[jp_pkg::A], buttons[jp_pkg::B]};

   // the action row wins when both select bits are set
   always_comb begin
      if (p1_sel[1]) begin
         row_data = act_row;
      end else if (p1_sel[0]) begin
         row_data = dir_row;
      end else begin
         row_data = 4'h0;
      end
   end

   assign ioreg_rdata = (ioreg_re && p1_hit) ? {4'h0, row_data} : 8'h00;

   assign any_pressed = |buttons;

   // interrupt on the first frame where something is held after nothing was
   always_ff @(posedge I_CLK) begin
      if (I_RESET) begin
         any_pressed_d <= 1'b0;
         joypad_irq    <= 1'b0;
      end else begin
         any_pressed_d <= any_pressed;
         joypad_irq    <= any_pressed & ~any_pressed_d;
      end
   end

endmodule

//--- pad_shift_reg.sv
module pad_shift_reg (
   input  logic             I_CLK,
   input  logic             I_RESET,
   pad_link_if.shifter      link,
   input  logic             pad_data,
   output jp_pkg::buttons_t buttons
);

   jp_pkg::buttons_t staging;   // frame being assembled bit by bit

   // the pad shifts out A, B, SELECT, START, UP, DOWN, LEFT, RIGHT
   function automatic jp_pkg::button_e serial_pos(input logic [2:0] idx);
      unique case (idx)
         3'd0: serial_pos = jp_pkg::A;
         3'd1: serial_pos = jp_pkg::B;
         3'd2: serial_pos = jp_pkg::SELECT;
         3'd3: serial_pos = jp_pkg::START;
         3'd4: serial_pos = jp_pkg::UP;
         3'd5: serial_pos = jp_pkg::DOWN;
         3'd6: serial_pos = jp_pkg::LEFT;
         3'd7: serial_pos = jp_pkg::RIGHT;
      endcase
   endfunction

   always_ff @(posedge I_CLK) begin
      if (link.sample) begin
         staging[serial_pos(link.bit_idx)] <= ~pad_data;   // data line is low when pressed
      end
   end

   // only whole frames become visible to the register side
   always_ff @(posedge I_CLK) begin
      if (I_RESET) begin
         buttons <= '0;
      end else if (link.frame_done) begin
         buttons <= staging;
      end
   end

endmodule

//--- pad_poll_fsm.sv
`include "jp_cfg.svh"

module pad_poll_fsm (
   input  logic     I_CLK,
   input  logic     I_RESET,
   pad_link_if.fsm  link,
   output logic     pad_latch,
   output logic     pad_pulse
);

   localparam int GAP_W = (`JP_POLL_GAP > 1) ? $clog2(`JP_POLL_GAP) : 1;
   localparam logic [GAP_W-1:0] GAP_LAST = GAP_W'(`JP_POLL_GAP - 1);
   localparam logic [2:0]       BIT_LAST = 3'(`JP_FRAME_BITS - 1);

   jp_pkg::poll_state_e state;
   logic [GAP_W-1:0]    gap_cnt;  // idle ticks spent before the next latch
   logic [2:0]          bit_cnt;  // serial bit currently on the pad data line

   assign link.bit_idx = bit_cnt;

   always_ff @(posedge I_CLK) begin
      if (I_RESET) begin
         state           <= jp_pkg::IDLE;
         gap_cnt         <= '0;
         bit_cnt         <= '0;
         pad_latch       <= 1'b0;
         pad_pulse       <= 1'b0;
         link.run        <= 1'b0;
         link.sample     <= 1'b0;
         link.frame_done <= 1'b0;
      end else begin
         link.run        <= 1'b1;   // the pad is polled continuously once out of reset
         link.sample     <= 1'b0;
         link.frame_done <= 1'b0;
         if (link.tick) begin
            unique case (state)
               jp_pkg::IDLE: begin
                  if (gap_cnt == GAP_LAST) begin
                     gap_cnt   <= '0;
                     pad_latch <= 1'b1;
                     state     <= jp_pkg::LATCH;
                  end else begin
                     gap_cnt <= gap_cnt + 1'b1;
                  end
               end
               jp_pkg::LATCH: begin
                  // the pad now drives its first bit, take it at the start of the slot
                  pad_latch   <= 1'b0;
                  bit_cnt     <= '0;
                  link.sample <= 1'b1;
                  state       <= jp_pkg::SAMPLE;
               end
               jp_pkg::SAMPLE: begin
                  if (bit_cnt == BIT_LAST) begin
                     link.frame_done <= 1'b1;   // eighth bit is already in the shifter
                     state           <= jp_pkg::DONE;
                  end else begin
                     pad_pulse <= 1'b1;
                     state     <= jp_pkg::PULSE;
                  end
               end
               jp_pkg::PULSE: begin
                  pad_pulse   <= 1'b0;   // the falling edge shifts the next bit out
                  bit_cnt     <= bit_cnt + 1'b1;
                  link.sample <= 1'b1;
                  state       <= jp_pkg::SAMPLE;
               end
               jp_pkg::DONE: begin
                  state <= jp_pkg::IDLE;
               end
               default: begin
                  state <= jp_pkg::IDLE;
               end
            endcase
         end
      end
   end

endmodule

//--- pad_bit_timer.sv
`include "jp_cfg.svh"

module pad_bit_timer (
   input logic       I_CLK,
   input logic       I_RESET,
   pad_link_if.timer link
);

   localparam int CNT_W = (`JP_TICK_DIV > 1) ? $clog2(`JP_TICK_DIV) : 1;
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`JP_TICK_DIV - 1);

   logic [CNT_W-1:0] div_cnt;
   logic             cnt_wrap;

   assign cnt_wrap = (div_cnt == CNT_LAST);

   // the divider only runs while the FSM asks for ticks
   always_ff @(posedge I_CLK) begin
      if (I_RESET || !link.run) begin
         div_cnt   <= '0;   // restart so the first tick comes a full period later
         link.tick <= 1'b0;
      end else begin
         link.tick <= cnt_wrap;
         if (cnt_wrap) begin
            div_cnt <= '0;
         end else begin
            div_cnt <= div_cnt + 1'b1;
         end
      end
   end

endmodule

//--- pad_link_if.sv
interface pad_link_if;

   logic       tick;       // one clock strobe per pad tick
   logic       run;        // keeps the tick divider counting
   logic       sample;     // take the current pad bit
   logic [2:0] bit_idx;    // serial position of the bit being sampled
   logic       frame_done; // all bits of the frame are in

   modport timer (
      output tick,
      input  run
   );

   // the FSM paces itself on tick and steers the shifter
   modport fsm (
      input  tick,
      output run,
      output sample,
      output bit_idx,
      output frame_done
   );

   modport shifter (
      input sample,
      input bit_idx,
      input frame_done
   );

endinterface

//--- jp_pkg.sv
package jp_pkg;

   // poll sequence, each state lasts one pad tick except IDLE which spans the gap
   typedef enum logic [2:0] {
      IDLE,
      LATCH,
      SAMPLE,
      PULSE,
      DONE
   } poll_state_e;

   // bit positions of the buttons inside a frame
   typedef enum int unsigned {
      RIGHT  = 0,
      LEFT   = 1,
      UP     = 2,
      DOWN   = 3,
      A      = 4,
      B      = 5,
      SELECT = 6,
      START  = 7
   } button_e;

   // one frame of buttons indexed by button_e, a set bit means pressed
   typedef logic [7:0] buttons_t;

endpackage

//--- jp_cfg.svh
`ifndef JP_CFG_SVH
`define JP_CFG_SVH

// address of the P1 joypad register in I/O space
`define JP_P1_ADDR 16'hFF00

// system clocks per pad tick
`define JP_TICK_DIV 4

// idle ticks between two polled frames
`define JP_POLL_GAP 6

// serial bits the pad shifts out per frame
`define JP_FRAME_BITS 8

`endif
